//--- hdl/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl import cache_pkg::*; #(
	parameter int ADDR_BITS = 24
) (
	input  logic                                  CLK,
	input  logic                                  reset,
	input  logic [29:0]                           cpu_addr,
	input  logic [31:0]                           cpu_din,
	input  logic [3:0]                            cpu_be,
	input  logic [3:0]                            cpu_burstcnt,
	input  logic                                  cpu_rd,
	input  logic                                  cpu_we,
	output logic                                  cpu_dout_ready,
	output logic                                  cpu_busy,
	output logic [ADDR_BITS:0]                    ddr_addr,
	output logic [63:0]                           ddr_din,
	output logic [7:0]                            ddr_be,
	output logic [7:0]                            ddr_burstcnt,
	output logic                                  ddr_rd,
	output logic                                  ddr_we,
	input  logic [63:0]                           ddr_dout,
	input  logic                                  ddr_dout_ready,
	input  logic                                  ddr_busy,
	output index_t                                index,
	output logic                                  tag_we,
	input  logic [ADDR_BITS-INDEX_BITS-BEAT_BITS:0] tags_rd [WAYS],
	input  valid_t                                valid_rd,
	output valid_t                                valid_wd,
	output logic                                  valid_we,
	output logic [WAYS-1:0]                       data_we,
	output logic [INDEX_BITS+BEAT_BITS-1:0]       data_waddr,
	output logic [63:0]                           data_wdata,
	output logic [7:0]                            data_wbe,
	output logic [INDEX_BITS+BEAT_BITS:0]         data_raddr,
	output way_t                                  sel_way,
	output logic                                  lru_init,
	output logic                                  lru_hit,
	input  way_t                                  victim
);

	localparam int TAG_BITS = ADDR_BITS + 1 - INDEX_BITS - BEAT_BITS;

	typedef enum logic [2:0] {
		sweep,
		idle,
		write_one,
		lookup,
		fill,
		tag_write
	} state_t;

	state_t               state;
	index_t               sweep_cnt;
	logic [ADDR_BITS:0]   read_addr;
	logic                 half;
	logic [3:0]           burst_left;
	logic [BEAT_BITS-1:0] fill_cnt;
	logic [TAG_BITS-1:0]  req_tag;
	logic [WAYS-1:0]      hit_vec;
	way_t                 hit_way;

	assign req_tag = read_addr[ADDR_BITS -: TAG_BITS];

	// Tag compare on all ways
	always_comb begin
		hit_vec = '0;
		hit_way = '0;
		for (int w = 0; w < WAYS; w++) begin
			if (valid_rd[w] && (tags_rd[w] == req_tag)) begin
				hit_vec[w] = 1'b1;
				hit_way    = way_t'(w);
			end
		end
	end

	assign cpu_busy = (state != idle) || ddr_busy;
	assign lru_init = (state == sweep);
	assign lru_hit  = cpu_dout_ready;
	assign tag_we   = (state == tag_write);
	assign valid_we = (state == sweep) || (state == tag_write);
	assign valid_wd = (state == sweep) ? '0 : (valid_rd | (valid_t'(1) << sel_way));
	assign index    = (state == sweep) ? sweep_cnt : read_addr[BEAT_BITS +: INDEX_BITS];

	// Fill beats go to the victim and write hits to the matching way
	always_comb begin
		data_we = '0;
		if (state == write_one) begin
			data_we = hit_vec;
		end else if ((state == fill) && ddr_dout_ready) begin
			data_we[sel_way] = 1'b1;
		end
	end

	assign data_waddr = {read_addr[BEAT_BITS +: INDEX_BITS],
		(state == fill) ? fill_cnt : read_addr[BEAT_BITS-1:0]};
	assign data_wdata = (state == fill) ? ddr_dout : ddr_din;
	assign data_wbe   = (state == fill) ? 8'hFF : ddr_be;

	always_ff @(posedge CLK) begin
		if (reset) begin
			state          <= sweep;
			sweep_cnt      <= '0;
			ddr_rd         <= 1'b0;
			ddr_we         <= 1'b0;
			cpu_dout_ready <= 1'b0;
		end else begin
			cpu_dout_ready <= 1'b0;

			// Commands stay up until memory takes them
			if (!ddr_busy) begin
				ddr_rd <= 1'b0;
				ddr_we <= 1'b0;
			end

			case (state)
				sweep: begin
					sweep_cnt <= sweep_cnt + 1'b1;
					if (sweep_cnt == index_t'(LINES - 1)) begin
						state <= idle;
					end
				end

				idle: begin
					if (!ddr_busy && (cpu_rd || cpu_we)) begin
						read_addr  <= cpu_addr[ADDR_BITS+1:1];
						half       <= cpu_addr[0];
						burst_left <= cpu_burstcnt;
						if (cpu_rd) begin
							state <= lookup;
						end else begin
							ddr_addr     <= cpu_addr[ADDR_BITS+1:1];
							ddr_din      <= {cpu_din, cpu_din};
							ddr_be       <= cpu_addr[0] ? {cpu_be, 4'h0} : {4'h0, cpu_be};
							ddr_burstcnt <= 8'd1;
							ddr_we       <= 1'b1;
							state        <= write_one;
						end
					end
				end

				write_one: begin
					state <= idle;
				end

				lookup: begin
					if (|hit_vec) begin
						cpu_dout_ready <= 1'b1;
						sel_way        <= hit_way;
						data_raddr     <= {read_addr[INDEX_BITS+BEAT_BITS-1:0], half};
						if (burst_left > 4'd1) begin
							burst_left <= burst_left - 1'b1;
							half       <= ~half;
							if (half) begin
								read_addr <= read_addr + 1'b1;
							end
						end else begin
							state <= idle;
						end
					end else begin
						// Miss fetches the whole line into the LRU way
						ddr_addr     <= {read_addr[ADDR_BITS:BEAT_BITS], {BEAT_BITS{1'b0}}};
						ddr_burstcnt <= 8'(LINE_BEATS);
						ddr_rd       <= 1'b1;
						sel_way      <= victim;
						fill_cnt     <= '0;
						state        <= fill;
					end
				end

				fill: begin
					if (ddr_dout_ready) begin
						fill_cnt <= fill_cnt + 1'b1;
						if (fill_cnt == BEAT_BITS'(LINE_BEATS - 1)) begin
							state <= tag_write;
						end
					end
				end

				tag_write: begin
					state <= lookup;
				end

				default: begin
					state <= idle;
				end
			endcase
		end
	end

endmodule

//--- hdl/cache_pkg.sv
package cache_pkg;

	// Cache geometry
	localparam int WAYS       = 4;
	localparam int WAY_BITS   = 2;
	localparam int LINES      = 128;
	localparam int INDEX_BITS = 7;
	localparam int LINE_BEATS = 8;
	localparam int BEAT_BITS  = 3;

	typedef logic [WAY_BITS-1:0]   way_t;
	typedef logic [INDEX_BITS-1:0] index_t;

	// One valid bit per way
	typedef logic [WAYS-1:0] valid_t;

	// Rank 0 is the most recent and rank WAYS-1 the victim
	typedef logic [WAY_BITS-1:0] lru_rank_t;

endpackage

//--- hdl/cache_ram.sv
`timescale 1ns/1ps

module cache_ram import cache_pkg::*; #(
	parameter type entry_t    = logic,
	parameter int  DEPTH_BITS = INDEX_BITS
) (
	input  logic   CLK,
	input  logic   we,
	input  index_t waddr,
	input  entry_t wdata,
	input  index_t raddr,
	output entry_t rdata
);

	entry_t mem [2**DEPTH_BITS];

	always_ff @(posedge CLK) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// Asynchronous read in the same cycle as the address
	assign rdata = mem[raddr];

endmodule

//--- hdl/l2_cache.sv
`timescale 1ns/1ps

module l2_cache import cache_pkg::*; #(
	parameter int ADDR_BITS = 24
) (
	input  logic               CLK,
	input  logic               reset,
	input  logic [29:0]        cpu_addr,
	input  logic [31:0]        cpu_din,
	output logic [31:0]        cpu_dout,
	output logic               cpu_dout_ready,
	input  logic [3:0]         cpu_be,
	input  logic [3:0]         cpu_burstcnt,
	output logic               cpu_busy,
	input  logic               cpu_rd,
	input  logic               cpu_we,
	output logic [ADDR_BITS:0] ddr_addr,
	output logic [63:0]        ddr_din,
	input  logic [63:0]        ddr_dout,
	input  logic               ddr_dout_ready,
	output logic [7:0]         ddr_be,
	output logic [7:0]         ddr_burstcnt,
	input  logic               ddr_busy,
	output logic               ddr_rd,
	output logic               ddr_we
);

	localparam int TAG_BITS = ADDR_BITS + 1 - INDEX_BITS - BEAT_BITS;

	typedef logic [TAG_BITS-1:0] tag_t;

	index_t                          index;
	logic                            tag_we;
	tag_t                            tags_rd [WAYS];
	valid_t                          valid_rd;
	valid_t                          valid_wd;
	logic                            valid_we;
	logic [WAYS-1:0]                 data_we;
	logic [INDEX_BITS+BEAT_BITS-1:0] data_waddr;
	logic [63:0]                     data_wdata;
	logic [7:0]                      data_wbe;
	logic [INDEX_BITS+BEAT_BITS:0]   data_raddr;
	logic [31:0]                     way_rdata [WAYS];
	way_t                            sel_way;
	way_t                            victim;
	logic                            lru_init;
	logic                            lru_hit;

	cache_ctrl #(
		.ADDR_BITS (ADDR_BITS)
	) u_ctrl (.*);

	for (genvar w = 0; w < WAYS; w++) begin : g_way
		// Tag comes from the line address still held on the DDR bus
		cache_ram #(
			.entry_t    (tag_t),
			.DEPTH_BITS (INDEX_BITS)
		) u_tag (
			.CLK   (CLK),
			.we    (tag_we && (sel_way == way_t'(w))),
			.waddr (index),
			.wdata (ddr_addr[ADDR_BITS -: TAG_BITS]),
			.raddr (index),
			.rdata (tags_rd[w])
		);

		line_data_ram u_data (
			.CLK   (CLK),
			.we    (data_we[w]),
			.waddr (data_waddr),
			.wdata (data_wdata),
			.wbe   (data_wbe),
			.raddr (data_raddr),
			.rdata (way_rdata[w])
		);
	end

	cache_ram #(
		.entry_t    (valid_t),
		.DEPTH_BITS (INDEX_BITS)
	) u_valid (
		.CLK   (CLK),
		.we    (valid_we),
		.waddr (index),
		.wdata (valid_wd),
		.raddr (index),
		.rdata (valid_rd)
	);

	lru_tracker u_lru (
		.CLK        (CLK),
		.reset      (reset),
		.init       (lru_init),
		.init_index (index),
		.index      (index),
		.hit        (lru_hit),
		.hit_way    (sel_way),
		.victim     (victim)
	);

	assign cpu_dout = way_rdata[sel_way];

endmodule

//--- hdl/line_data_ram.sv
`timescale 1ns/1ps

module line_data_ram import cache_pkg::*; (
	input  logic                          CLK,
	input  logic                          we,
	input  logic [INDEX_BITS+BEAT_BITS-1:0] waddr,
	input  logic [63:0]                   wdata,
	input  logic [7:0]                    wbe,
	input  logic [INDEX_BITS+BEAT_BITS:0] raddr,
	output logic [31:0]                   rdata
);

	logic [7:0][7:0] mem [LINES*LINE_BEATS];
	logic [63:0]     rd_word;

	// Byte-enabled 64-bit write port
	always_ff @(posedge CLK) begin
		if (we) begin
			for (int b = 0; b < 8; b++) begin
				if (wbe[b]) begin
					mem[waddr][b] <= wdata[8*b +: 8];
				end
			end
		end
	end

	assign rd_word = mem[raddr[INDEX_BITS+BEAT_BITS:1]];

	// Lowest read address bit picks the 32-bit half
	assign rdata = raddr[0] ? rd_word[63:32] : rd_word[31:0];

endmodule

//--- hdl/lru_tracker.sv
`timescale 1ns/1ps

module lru_tracker import cache_pkg::*; (
	input  logic   CLK,
	input  logic   reset,
	input  logic   init,
	input  index_t init_index,
	input  index_t index,
	input  logic   hit,
	input  way_t   hit_way,
	output way_t   victim
);

	typedef lru_rank_t [WAYS-1:0] rank_vec_t;

	rank_vec_t rd_ranks;
	rank_vec_t prev_ranks;
	rank_vec_t seed_ranks;
	rank_vec_t upd_ranks;
	rank_vec_t wr_ranks;
	index_t    prev_index;
	index_t    wr_index;
	lru_rank_t hit_rank;
	logic      wr_en;

	cache_ram #(
		.entry_t    (rank_vec_t),
		.DEPTH_BITS (INDEX_BITS)
	) u_ranks (
		.CLK   (CLK),
		.we    (wr_en),
		.waddr (wr_index),
		.wdata (wr_ranks),
		.raddr (index),
		.rdata (rd_ranks)
	);

	// Hit pulse trails the lookup by one cycle, so keep that line's ranks
	always_ff @(posedge CLK) begin
		prev_index <= index;
		prev_ranks <= rd_ranks;
	end

	// Move to front
	always_comb begin
		hit_rank = prev_ranks[hit_way];
		for (int w = 0; w < WAYS; w++) begin
			seed_ranks[w] = lru_rank_t'(w);
			if (way_t'(w) == hit_way) begin
				upd_ranks[w] = '0;
			end else if (prev_ranks[w] < hit_rank) begin
				upd_ranks[w] = prev_ranks[w] + 1'b1;
			end else begin
				upd_ranks[w] = prev_ranks[w];
			end
		end
	end

	assign wr_en    = init || (hit && !reset);
	assign wr_index = init ? init_index : prev_index;
	assign wr_ranks = init ? seed_ranks : upd_ranks;

	always_comb begin
		victim = '0;
		for (int w = 0; w < WAYS; w++) begin
			if (rd_ranks[w] == lru_rank_t'(WAYS - 1)) begin
				victim = way_t'(w);
			end
		end
	end

endmodule

//--- project.f
hdl/cache_pkg.sv
hdl/cache_ram.sv
hdl/line_data_ram.sv
hdl/lru_tracker.sv
hdl/cache_ctrl.sv
hdl/l2_cache.sv
tests/l2_cache_chk.sv
tests/tb_l2_cache.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_l2_cache -f project.f -o sim_l2_cache
./obj_dir/sim_l2_cache 2>&1 | tee sim.log

if grep -q "sim failed" sim.log; then
	exit 1
fi
exit 0

//--- tests/l2_cache_chk.sv
`timescale 1ns/1ps

module l2_cache_chk #(
	parameter int ADDR_BITS = 24
) (
	input logic               CLK,
	input logic               reset,
	input logic               ddr_rd,
	input logic               ddr_we,
	input logic               ddr_busy,
	input logic [ADDR_BITS:0] ddr_addr,
	input logic [63:0]        ddr_din,
	input logic [7:0]         ddr_be,
	input logic [7:0]         ddr_burstcnt
);

	int fail_count = 0;

	rd_we_excl: assert property (@(posedge CLK) disable iff (reset) !(ddr_rd && ddr_we))
		else begin
			$error("ddr_rd and ddr_we high together");
			fail_count++;
		end

	we_single: assert property (@(posedge CLK) disable iff (reset)
		ddr_we |-> (ddr_burstcnt == 8'd1))
		else begin
			$error("ddr_we with ddr_burstcnt %h", ddr_burstcnt);
			fail_count++;
		end

	rd_line: assert property (@(posedge CLK) disable iff (reset)
		ddr_rd |-> (ddr_burstcnt == 8'd8))
		else begin
			$error("ddr_rd with ddr_burstcnt %h", ddr_burstcnt);
			fail_count++;
		end

	// Memory has not taken the command yet
	cmd_hold: assert property (@(posedge CLK) disable iff (reset)
		((ddr_rd || ddr_we) && ddr_busy) |=> ($stable(ddr_rd) && $stable(ddr_we)
		&& $stable(ddr_addr) && $stable(ddr_burstcnt) && $stable(ddr_din) && $stable(ddr_be)))
		else begin
			$error("DDR command changed while ddr_busy was high");
			fail_count++;
		end

endmodule

//--- tests/tb_l2_cache.sv
`timescale 1ns/1ps

module tb_l2_cache;

	localparam int ADDR_BITS = 24;
	localparam int MEM_WORDS = 8192;
	localparam int SWEEP_LEN = 128;
	// Sweep plus a dozen line fills under random stalls and a wide margin
	localparam int MAX_CYCLES = 20000;

	logic               CLK;
	logic               reset;
	logic [29:0]        cpu_addr;
	logic [31:0]        cpu_din;
	logic [31:0]        cpu_dout;
	logic               cpu_dout_ready;
	logic [3:0]         cpu_be;
	logic [3:0]         cpu_burstcnt;
	logic               cpu_busy;
	logic               cpu_rd;
	logic               cpu_we;
	logic [ADDR_BITS:0] ddr_addr;
	logic [63:0]        ddr_din;
	logic [63:0]        ddr_dout;
	logic               ddr_dout_ready;
	logic [7:0]         ddr_be;
	logic [7:0]         ddr_burstcnt;
	logic               ddr_busy;
	logic               ddr_rd;
	logic               ddr_we;

	logic [63:0]        mem [MEM_WORDS];
	int                 seed;
	int                 errors;
	int                 checks;
	int                 cycles;
	int                 rd_cmds;
	int                 wr_cmds;
	logic               stall_en;
	logic [ADDR_BITS:0] last_addr;
	logic [7:0]         last_cnt;
	logic [63:0]        last_din;
	logic [7:0]         last_be;
	int                 lat [16];
	logic [31:0]        words [16];

	l2_cache #(
		.ADDR_BITS (ADDR_BITS)
	) dut (.*);

	bind cache_ctrl l2_cache_chk #(
		.ADDR_BITS (ADDR_BITS)
	) u_chk (
		.CLK          (CLK),
		.reset        (reset),
		.ddr_rd       (ddr_rd),
		.ddr_we       (ddr_we),
		.ddr_busy     (ddr_busy),
		.ddr_addr     (ddr_addr),
		.ddr_din      (ddr_din),
		.ddr_be       (ddr_be),
		.ddr_burstcnt (ddr_burstcnt)
	);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	// DDR model with random stalls and gaps between read beats
	initial begin
		logic               take_rd;
		logic               take_wr;
		logic [ADDR_BITS:0] cmd_addr;
		logic [63:0]        cmd_din;
		logic [7:0]         cmd_be;
		logic [7:0]         cmd_cnt;
		logic [12:0]        rd_ptr;
		int                 rd_left;
		seed           = 32'h9ad1_fbd2;
		rd_cmds        = 0;
		wr_cmds        = 0;
		rd_left        = 0;
		rd_ptr         = '0;
		ddr_busy       = 1'b0;
		ddr_dout       = '0;
		ddr_dout_ready = 1'b0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i] = {16'hd00d ^ 16'(i), 16'(i * 3), ~16'(i), 16'(i)};
		end
		forever begin
			@(negedge CLK);
			take_rd  = !reset && ddr_rd && !ddr_busy;
			take_wr  = !reset && ddr_we && !ddr_busy;
			cmd_addr = ddr_addr;
			cmd_din  = ddr_din;
			cmd_be   = ddr_be;
			cmd_cnt  = ddr_burstcnt;
			@(posedge CLK);
			#1;
			if (take_wr) begin
				wr_cmds++;
				last_addr = cmd_addr;
				last_din  = cmd_din;
				last_be   = cmd_be;
				last_cnt  = cmd_cnt;
				for (int b = 0; b < 8; b++) begin
					if (cmd_be[b]) begin
						mem[cmd_addr[12:0]][8*b +: 8] = cmd_din[8*b +: 8];
					end
				end
			end
			if (take_rd) begin
				rd_cmds++;
				last_addr = cmd_addr;
				last_cnt  = cmd_cnt;
				rd_ptr    = cmd_addr[12:0];
				rd_left   = int'(cmd_cnt);
			end
			ddr_dout_ready = 1'b0;
			if ((rd_left > 0) && (($random(seed) & 3) != 0)) begin
				ddr_dout       = mem[rd_ptr];
				ddr_dout_ready = 1'b1;
				rd_ptr++;
				rd_left--;
			end
			ddr_busy = (rd_left > 0) || (stall_en && (($random(seed) & 3) == 0));
		end
	end

	initial begin
		cycles = 0;
		while (cycles < MAX_CYCLES) begin
			@(posedge CLK);
			cycles++;
		end
		$display("Run did not finish within %0d cycles", MAX_CYCLES);
		$display("sim failed");
		$finish;
	end

	function automatic logic [31:0] mem_word32(input logic [29:0] a);
		return a[0] ? mem[a[13:1]][63:32] : mem[a[13:1]][31:0];
	endfunction

	task automatic next_cycle();
		@(posedge CLK);
		#1;
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("Error: %s is %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic expect_true(input logic cond, input string msg);
		checks++;
		assert (cond) else begin
			$display("%s", msg);
			errors++;
		end
	endtask

	// Holds the request until an edge with cpu_busy low
	task automatic wait_accept(output logic ok);
		int n;
		ok = 1'b0;
		n  = 0;
		while (!ok && n < 500) begin
			@(negedge CLK);
			ok = !cpu_busy;
			next_cycle();
			n++;
		end
		cpu_rd = 1'b0;
		cpu_we = 1'b0;
		expect_true(ok, "CPU request was never accepted");
	endtask

	task automatic cpu_read(input logic [29:0] addr, input int cnt, input int fills);
		int          got;
		int          n;
		int          rd_before;
		logic        ok;
		logic [29:0] a;
		rd_before    = rd_cmds;
		cpu_addr     = addr;
		cpu_burstcnt = 4'(cnt);
		cpu_rd       = 1'b1;
		wait_accept(ok);
		got = 0;
		n   = 0;
		while (ok && (got < cnt) && (n < 400)) begin
			@(negedge CLK);
			n++;
			if (cpu_dout_ready) begin
				a          = addr + 30'(got);
				words[got] = cpu_dout;
				lat[got]   = n;
				check_value("cpu_dout", 64'(cpu_dout), 64'(mem_word32(a)));
				got++;
			end
			next_cycle();
		end
		expect_true(got == cnt, "Read burst did not return all of its words");
		check_value("ddr_rd count", 64'(rd_cmds - rd_before), 64'(fills));
		if (fills > 0) begin
			check_value("ddr_addr", 64'(last_addr), 64'({addr[25:4], 3'b000}));
			check_value("ddr_burstcnt", 64'(last_cnt), 64'd8);
		end
	endtask

	task automatic reset_sweep_idle();
		int   busy_cycles;
		logic done;
		busy_cycles = 0;
		done        = 1'b0;
		while (!done && (busy_cycles < SWEEP_LEN + 50)) begin
			@(negedge CLK);
			expect_true(!ddr_rd && !ddr_we && !cpu_dout_ready,
				"DDR command or read data seen during the reset sweep");
			if (cpu_busy) begin
				busy_cycles++;
			end else begin
				done = 1'b1;
			end
			next_cycle();
		end
		check_value("cpu_busy cycles", 64'(busy_cycles), 64'(SWEEP_LEN));
		// Idle with no request
		repeat (4) begin
			@(negedge CLK);
			expect_true(!ddr_rd && !ddr_we && !cpu_dout_ready,
				"DDR command or read data seen with no request");
			next_cycle();
		end
	endtask

	task automatic miss_then_fill();
		cpu_read(30'h125, 1, 1);
	endtask

	task automatic same_line_hit();
		cpu_read(30'h12a, 1, 0);
		check_value("cpu_dout_ready latency", 64'(lat[0]), 64'd2);
	endtask

	task automatic odd_word_burst();
		cpu_read(30'h127, 4, 0);
		// Whole burst hits, one word per cycle after the hit latency
		for (int i = 0; i < 4; i++) begin
			check_value("cpu_dout_ready latency", 64'(lat[i]), 64'(2 + i));
		end
	endtask

	task automatic masked_write_through();
		logic [31:0] old_word;
		logic [31:0] merged;
		int          wr_before;
		int          n;
		logic        ok;
		old_word     = mem_word32(30'h12b);
		merged       = {old_word[31:24], 8'hb2, old_word[15:8], 8'hd4};
		wr_before    = wr_cmds;
		cpu_addr     = 30'h12b;
		cpu_din      = 32'ha1b2_c3d4;
		cpu_be       = 4'b0101;
		cpu_burstcnt = 4'd1;
		cpu_we       = 1'b1;
		wait_accept(ok);
		n = 0;
		while ((wr_cmds == wr_before) && (n < 100)) begin
			next_cycle();
			n++;
		end
		expect_true(wr_cmds == wr_before + 1, "Write never reached the DDR bus");
		check_value("ddr_addr", 64'(last_addr), 64'(30'h12b >> 1));
		check_value("ddr_be", 64'(last_be), 64'h50);
		check_value("ddr_din", last_din, 64'ha1b2_c3d4_a1b2_c3d4);
		check_value("ddr_burstcnt", 64'(last_cnt), 64'd1);
		// Line is cached, so the merged word comes back without a fetch
		cpu_read(30'h12b, 1, 0);
		check_value("cpu_dout", 64'(words[0]), 64'(merged));
	endtask

	task automatic lru_eviction();
		// Lines 0x800 words apart share set 0x40
		for (int k = 0; k < 5; k++) begin
			cpu_read(30'h400 + 30'(k) * 30'h800, 1, 1);
		end
		cpu_read(30'h400, 1, 1);
		cpu_read(30'h2400, 1, 0);
	endtask

	initial begin
		reset        = 1'b1;
		cpu_addr     = '0;
		cpu_din      = '0;
		cpu_be       = '0;
		cpu_burstcnt = '0;
		cpu_rd       = 1'b0;
		cpu_we       = 1'b0;
		stall_en     = 1'b0;
		errors       = 0;
		checks       = 0;
		repeat (10) @(posedge CLK);
		#1;
		reset = 1'b0;
		reset_sweep_idle();
		stall_en = 1'b1;
		miss_then_fill();
		same_line_hit();
		odd_word_burst();
		masked_write_through();
		lru_eviction();
		$display("Checks: %0d, errors: %0d, assertion failures: %0d",
			checks, errors, dut.u_ctrl.u_chk.fail_count);
		if ((errors == 0) && (dut.u_ctrl.u_chk.fail_count == 0)) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule
